// ==== video_blank_config.svh ====
/*
 * Video blanking configuration.
 * Stream widths, counter widths, FIFO depth and blank pixel value.
 */
`ifndef VIDEO_BLANK_CONFIG_SVH
`define VIDEO_BLANK_CONFIG_SVH

// ---------------------------------------------------------------------------
// stream beat
// ---------------------------------------------------------------------------
`define VB_TDATA_WIDTH      8
// bit 0 marks frame start
`define VB_TUSER_WIDTH      1

// ---------------------------------------------------------------------------
// frame geometry
// ---------------------------------------------------------------------------
`define VB_IMG_X_WIDTH      10
`define VB_IMG_Y_WIDTH      10
`define VB_BLANK_Y_WIDTH    8

// elastic buffer holds 2**n entries
`define VB_FIFO_DEPTH_LOG2  4

`define VB_BLANK_TDATA      8'h10
// zero means height unknown, no blanking until measured
`define VB_INIT_Y_NUM       0

`endif

// ==== video_blank_pkg.sv ====
/*
 * Video blanking types.
 * Beat struct of the pixel stream and the frame size types.
 */
`include "video_blank_config.svh"

package video_blank_pkg;

    // ------------------------------------------------------------------------
    // one stream beat, 10 bits with the default widths
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [`VB_TUSER_WIDTH-1:0] tuser;
        logic                       tlast;
        logic [`VB_TDATA_WIDTH-1:0] tdata;
    } axis_beat_t;

    // ------------------------------------------------------------------------
    // frame size
    // ------------------------------------------------------------------------

    // index of the last pixel in a line
    typedef logic [`VB_IMG_X_WIDTH-1:0] x_num_t;

    // index of the last line in a frame
    typedef logic [`VB_IMG_Y_WIDTH-1:0] y_num_t;

    // number of blank lines after a frame
    typedef logic [`VB_BLANK_Y_WIDTH-1:0] blank_num_t;

endpackage

// ==== stream_fifo.sv ====
/*
 * Stream FIFO.
 * Synchronous valid/ready buffer for any beat type, with a
 * registered output stage so the sink sees stable data.
 */
`timescale 1ns/10ps
`include "video_blank_config.svh"

module stream_fifo #(
    parameter type beat_t     = video_blank_pkg::axis_beat_t,
    parameter int  DEPTH_LOG2 = `VB_FIFO_DEPTH_LOG2
) (
    input  logic  aclk,
    input  logic  aresetn,

    input  beat_t s_beat,
    input  logic  s_valid,
    output logic  s_ready,

    output beat_t m_beat,
    output logic  m_valid,
    input  logic  m_ready
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    beat_t                 mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  wr_en;
    logic                  rd_en;

    assign s_ready = (count != (DEPTH_LOG2 + 1)'(DEPTH));
    assign wr_en   = s_valid && s_ready;

    // refill the output stage when it is empty or being drained
    assign rd_en   = (count != '0) && (!m_valid || m_ready);

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_beat;
        end
        if (rd_en) begin
            m_beat <= mem[rd_ptr];
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            m_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            if (rd_en) begin
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    // a stalled output beat is held until taken
    a_hold_stalled_beat : assert property (
        @(posedge aclk) disable iff (!aresetn)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_beat))
    );

endmodule

// ==== frame_size_meter.sv ====
/*
 * Frame size meter.
 * Watches accepted beats to learn the line width and frame height.
 */
`timescale 1ns/10ps
`include "video_blank_config.svh"

module frame_size_meter (
    input  logic                        aclk,
    input  logic                        aresetn,

    input  video_blank_pkg::axis_beat_t beat,
    input  logic                        valid,
    input  logic                        ready,

    output video_blank_pkg::x_num_t     x_num,
    output video_blank_pkg::y_num_t     y_num,
    output video_blank_pkg::y_num_t     y_count
);

    video_blank_pkg::x_num_t x_count;
    logic                    xfer;

    assign xfer = valid && ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            x_count <= '0;
            y_count <= '0;
            x_num   <= '0;
            y_num   <= video_blank_pkg::y_num_t'(`VB_INIT_Y_NUM);
        end else if (xfer) begin
            x_count <= x_count + 1'b1;

            if (beat.tlast) begin
                // last pixel index of this line
                x_num   <= x_count;
                x_count <= '0;
                y_count <= y_count + 1'b1;
            end

            if (beat.tuser[0]) begin
                // previous frame had lines, keep its last line index
                if (y_count != '0) begin
                    y_num <= y_count - 1'b1;
                end
                // a one pixel line already completes on the start beat
                y_count <= beat.tlast ? video_blank_pkg::y_num_t'(1) : '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    // frame start only on the first pixel of a line
    a_tuser_line_start : assert property (
        @(posedge aclk) disable iff (!aresetn)
        (xfer && beat.tuser[0]) |-> (x_count == '0)
    );

endmodule

// ==== vblank_inserter.sv ====
/*
 * Vertical blanking inserter.
 * Single output register; passes pixels and appends blank lines
 * of the measured width after the last line of each frame.
 */
`timescale 1ns/10ps
`include "video_blank_config.svh"

module vblank_inserter (
    input  logic                        aclk,
    input  logic                        aresetn,

    input  video_blank_pkg::blank_num_t blank_num,
    input  video_blank_pkg::x_num_t     x_num,
    input  video_blank_pkg::y_num_t     y_num,
    input  video_blank_pkg::y_num_t     y_count,

    input  video_blank_pkg::axis_beat_t s_beat,
    input  logic                        s_valid,
    output logic                        s_ready,

    output video_blank_pkg::axis_beat_t m_beat,
    output logic                        m_valid,
    input  logic                        m_ready
);

    logic                        cke;
    logic                        blank;
    logic                        frame_last;
    logic                        last_line;
    logic                        blank_done;
    logic                        x_blank_last;
    video_blank_pkg::x_num_t     x_blank;
    video_blank_pkg::blank_num_t y_blank;

    // output register free or draining
    assign cke = !m_valid || m_ready;

    // input taken in pass mode or at the decision after a line
    assign s_ready = cke && (!blank || frame_last);

    // tlast beat closing the last measured line, height known
    assign last_line = s_beat.tlast && (y_num != '0) && (y_count == y_num);

    assign blank_done   = (y_blank == blank_num);
    assign x_blank_last = (video_blank_pkg::x_num_t'(x_blank + 1'b1) == x_num);

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            blank      <= 1'b0;
            frame_last <= 1'b0;
            x_blank    <= '0;
            y_blank    <= '0;
            m_valid    <= 1'b0;
        end else if (cke) begin
            frame_last <= 1'b0;

            if (frame_last) begin
                if (s_valid || blank_done) begin
                    // next frame waiting or run complete
                    blank   <= 1'b0;
                    m_valid <= s_valid;
                end else begin
                    // open another blank line
                    blank      <= 1'b1;
                    x_blank    <= '0;
                    y_blank    <= y_blank + 1'b1;
                    m_valid    <= 1'b1;
                    frame_last <= (x_num == '0);
                end
            end else if (blank) begin
                x_blank    <= x_blank + 1'b1;
                m_valid    <= 1'b1;
                frame_last <= x_blank_last;
            end else begin
                m_valid <= s_valid;
                y_blank <= '0;
                if (s_valid) begin
                    frame_last <= last_line && (blank_num != '0);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // output beat
    // ------------------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (cke) begin
            if (frame_last && !(s_valid || blank_done)) begin
                m_beat.tuser <= '0;
                m_beat.tlast <= (x_num == '0);
                m_beat.tdata <= `VB_BLANK_TDATA;
            end else if (blank && !frame_last) begin
                m_beat.tuser <= '0;
                m_beat.tlast <= x_blank_last;
                m_beat.tdata <= `VB_BLANK_TDATA;
            end else begin
                m_beat <= s_beat;
            end
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    // an offered beat stays until the sink takes it
    a_valid_held : assert property (
        @(posedge aclk) disable iff (!aresetn)
        (m_valid && !m_ready) |=> m_valid
    );

    // no input while a blank line is short of its last beat
    a_blank_blocks_input : assert property (
        @(posedge aclk) disable iff (!aresetn)
        (blank && !m_beat.tlast) |-> !s_ready
    );

endmodule

// ==== video_blank_top.sv ====
/*
 * Video stream conditioner.
 * Elastic FIFO, frame size meter and vertical blank inserter.
 */
`timescale 1ns/10ps

module video_blank_top (
    input  logic                        aclk,
    input  logic                        aresetn,

    input  video_blank_pkg::blank_num_t blank_num,

    input  video_blank_pkg::axis_beat_t s_beat,
    input  logic                        s_valid,
    output logic                        s_ready,

    output video_blank_pkg::axis_beat_t m_beat,
    output logic                        m_valid,
    input  logic                        m_ready,

    output video_blank_pkg::x_num_t     monitor_x_num,
    output video_blank_pkg::y_num_t     monitor_y_num
);

    // fifo to inserter link
    video_blank_pkg::axis_beat_t fifo_beat;
    logic                        fifo_valid;
    logic                        fifo_ready;

    video_blank_pkg::x_num_t     x_num;
    video_blank_pkg::y_num_t     y_num;
    video_blank_pkg::y_num_t     y_count;

    stream_fifo #(
        .beat_t (video_blank_pkg::axis_beat_t)
    ) stream_fifo_inst (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (fifo_beat),
        .m_valid (fifo_valid),
        .m_ready (fifo_ready)
    );

    // watches the link only
    frame_size_meter frame_size_meter_inst (
        .aclk    (aclk),
        .aresetn (aresetn),
        .beat    (fifo_beat),
        .valid   (fifo_valid),
        .ready   (fifo_ready),
        .x_num   (x_num),
        .y_num   (y_num),
        .y_count (y_count)
    );

    vblank_inserter vblank_inserter_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .blank_num (blank_num),
        .x_num     (x_num),
        .y_num     (y_num),
        .y_count   (y_count),
        .s_beat    (fifo_beat),
        .s_valid   (fifo_valid),
        .s_ready   (fifo_ready),
        .m_beat    (m_beat),
        .m_valid   (m_valid),
        .m_ready   (m_ready)
    );

    assign monitor_x_num = x_num;
    assign monitor_y_num = y_num;

endmodule

// ==== tb_clock_gen.sv ====
/*
 * Testbench clock and reset source.
 * Free running clock, reset held low for a set number of cycles.
 */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
    end

endmodule

// ==== tb_video_blank_top.sv ====
/*
 * Testbench for the video stream conditioner.
 * Sends 6x4 frames, models the expected output stream and checks it.
 */
`timescale 1ns/10ps
`include "video_blank_config.svh"

module tb_video_blank_top;

    localparam int LINE_PIXELS = 6;
    localparam int FRAME_LINES = 4;
    localparam int IDLE_CYCLES = 40;
    localparam int EARLY_GAP   = 8;
    // 9 frames of at most 280 cycles at 4 ns, doubled
    localparam int WATCHDOG_NS = 9 * 280 * 4 * 2;

    logic                        aclk;
    logic                        aresetn;
    video_blank_pkg::blank_num_t blank_num;
    video_blank_pkg::axis_beat_t s_beat;
    logic                        s_valid;
    logic                        s_ready;
    video_blank_pkg::axis_beat_t m_beat;
    logic                        m_valid;
    logic                        m_ready;
    video_blank_pkg::x_num_t     monitor_x_num;
    video_blank_pkg::y_num_t     monitor_y_num;

    string test_name;
    int    value_errors;
    int    other_errors;
    logic  random_ready;
    logic  early_mode;

    // reference model state
    video_blank_pkg::axis_beat_t exp_q[$];
    video_blank_pkg::axis_beat_t exp_head;
    video_blank_pkg::axis_beat_t blank_beat;
    int   exp_count;
    int   out_frames;
    int   out_lines;
    int   blank_pos;
    int   blank_lines;
    int   run_target;
    logic run_early;
    logic window;
    logic out_xfer;
    logic blank_slot;
    logic run_close;
    logic run_len_ok;

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(10)) tb_clock_gen_inst (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    video_blank_top video_blank_top_inst (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .blank_num     (blank_num),
        .s_beat        (s_beat),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .m_beat        (m_beat),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .monitor_x_num (monitor_x_num),
        .monitor_y_num (monitor_y_num)
    );

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    assign out_xfer   = m_valid && m_ready;
    assign blank_slot = window && !m_beat.tuser[0];
    assign run_close  = out_xfer && window && m_beat.tuser[0];
    assign run_len_ok = run_early ? (blank_lines < run_target) : (blank_lines == run_target);

    always_comb begin
        blank_beat.tuser = '0;
        blank_beat.tlast = (blank_pos == LINE_PIXELS - 1);
        blank_beat.tdata = `VB_BLANK_TDATA;
    end

    always @(posedge aclk) begin
        if (!aresetn) begin
            exp_q.delete();
            exp_head    <= '0;
            exp_count   <= 0;
            out_frames  <= 0;
            out_lines   <= 0;
            window      <= 1'b0;
            blank_pos   <= 0;
            blank_lines <= 0;
            run_target  <= 0;
            run_early   <= 1'b0;
        end else begin
            if (s_valid && s_ready) begin
                exp_q.push_back(s_beat);
            end
            if (out_xfer && blank_slot) begin
                blank_pos <= m_beat.tlast ? 0 : blank_pos + 1;
                if (m_beat.tlast) begin
                    blank_lines <= blank_lines + 1;
                end
            end else if (out_xfer) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                if (m_beat.tuser[0]) begin
                    window     <= 1'b0;
                    out_frames <= out_frames + 1;
                end
                if (m_beat.tlast) begin
                    out_lines <= (out_lines == FRAME_LINES - 1) ? 0 : out_lines + 1;
                    // height known from the second frame on
                    if (out_lines == FRAME_LINES - 1 && out_frames >= 2) begin
                        window      <= 1'b1;
                        blank_pos   <= 0;
                        blank_lines <= 0;
                        run_target  <= int'(blank_num);
                        run_early   <= early_mode;
                    end
                end
            end
            exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
            exp_count <= exp_q.size();
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_reset_quiet : assert property (@(posedge aclk) !aresetn |=> !m_valid)
        else begin
            other_errors++;
            $display("%s: m_valid went high while reset was held", test_name);
        end

    a_pixel_match : assert property (@(posedge aclk) disable iff (!aresetn)
        (out_xfer && !blank_slot) |-> (exp_count != 0 && m_beat == exp_head))
        else begin
            value_errors++;
            $display("[FAIL] %s: pixel expected %h actual %h (%0d queued)", test_name,
                     $sampled(exp_head), $sampled(m_beat), $sampled(exp_count));
        end

    a_blank_shape : assert property (@(posedge aclk) disable iff (!aresetn)
        (out_xfer && blank_slot) |-> (m_beat == blank_beat))
        else begin
            value_errors++;
            $display("[FAIL] %s: blank beat expected %h actual %h", test_name,
                     $sampled(blank_beat), $sampled(m_beat));
        end

    a_blank_count : assert property (@(posedge aclk) disable iff (!aresetn)
        (out_xfer && blank_slot) |-> (blank_lines < run_target))
        else begin
            value_errors++;
            $display("[FAIL] %s: blank lines expected at most %0d actual %0d", test_name,
                     $sampled(run_target), $sampled(blank_lines) + 1);
        end

    // runs end on a line boundary with the right number of lines
    a_run_close : assert property (@(posedge aclk) disable iff (!aresetn)
        run_close |-> (blank_pos == 0 && run_len_ok))
        else begin
            value_errors++;
            $display("[FAIL] %s: blank run expected %s%0d lines actual %0d lines %0d beats",
                     test_name, $sampled(run_early) ? "under " : "", $sampled(run_target),
                     $sampled(blank_lines), $sampled(blank_pos));
        end

    a_monitor : assert property (@(posedge aclk) disable iff (!aresetn)
        (out_frames >= 2) |->
        (monitor_x_num == video_blank_pkg::x_num_t'(LINE_PIXELS - 1) &&
         monitor_y_num == video_blank_pkg::y_num_t'(FRAME_LINES - 1)))
        else begin
            value_errors++;
            $display("[FAIL] %s: monitor expected %0d/%0d actual %0d/%0d", test_name,
                     LINE_PIXELS - 1, FRAME_LINES - 1,
                     $sampled(monitor_x_num), $sampled(monitor_y_num));
        end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic send_frame();
        video_blank_pkg::axis_beat_t b;
        for (int line = 0; line < FRAME_LINES; line++) begin
            for (int px = 0; px < LINE_PIXELS; px++) begin
                b.tuser = (line == 0 && px == 0);
                b.tlast = (px == LINE_PIXELS - 1);
                b.tdata = 8'($urandom);
                s_beat  = b;
                s_valid = 1'b1;
                while (!s_ready) @(negedge aclk);
                @(negedge aclk);
            end
        end
        s_valid = 1'b0;
    endtask

    // all pixels out and the blank run complete
    task automatic wait_drained();
        while (exp_count != 0 || (window && blank_lines != run_target)) @(negedge aclk);
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) @(negedge aclk);
    endtask

    initial begin
        m_ready = 1'b1;
        forever begin
            @(negedge aclk);
            m_ready = random_ready ? ($urandom % 4 != 0) : 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("%s: watchdog expired, the output stream stopped", test_name);
        $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(2));
        test_name    = "reset";
        s_beat       = '0;
        s_valid      = 1'b0;
        blank_num    = 8'd2;
        random_ready = 1'b0;
        early_mode   = 1'b0;
        @(posedge aresetn);
        @(negedge aclk);

        test_name = "first_frame";
        send_frame();
        wait_drained();
        idle_cycles(IDLE_CYCLES);

        test_name = "blank_lines";
        repeat (2) begin
            send_frame();
            wait_drained();
            idle_cycles(IDLE_CYCLES);
        end

        test_name    = "back_pressure";
        random_ready = 1'b1;
        repeat (3) begin
            send_frame();
            wait_drained();
            idle_cycles(IDLE_CYCLES);
        end
        random_ready = 1'b0;

        // next frame arrives while blanking is still running
        test_name  = "early_end";
        blank_num  = 8'd8;
        early_mode = 1'b1;
        repeat (3) begin
            send_frame();
            idle_cycles(EARLY_GAP);
        end
        wait_drained();
        idle_cycles(IDLE_CYCLES);

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== video_blank_top.f ====
+incdir+.
video_blank_pkg.sv
stream_fifo.sv
frame_size_meter.sv
vblank_inserter.sv
video_blank_top.sv
tb_clock_gen.sv
tb_video_blank_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_video_blank_top
FILELIST = video_blank_top.f
LOG      = sim.log
SIM      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(SIM) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
